// File: Makefile
# Verilator flow for the systolic matrix multiplier

VERILATOR ?= verilator
TOP       ?= matmul_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/matmul_checker.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module matmul_checker
  import mm_ctrl_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      start,
  input read_req_t rd_req,
  input read_rsp_t rd_rsp,
  input logic      busy,
  input logic      done
);

  logic start_ok;
  logic read_ok;

  assign start_ok = start && !busy;
  assign read_ok  = rd_req.en && !busy;

  // done at a fixed distance from an accepted start, and never alone
  done_after_start: assert property (
    @(posedge clk) disable iff (reset) start_ok |-> ##(`MM_DONE_LATENCY) done
  ) else $error("done missing %0d cycles after an accepted start", `MM_DONE_LATENCY);

  done_has_start: assert property (
    @(posedge clk) disable iff (reset) done |-> $past(start_ok, `MM_DONE_LATENCY)
  ) else $error("done pulsed without an accepted start before it");

  read_after_req: assert property (
    @(posedge clk) disable iff (reset) read_ok |-> ##(`MM_READ_LATENCY) rd_rsp.valid
  ) else $error("rd_rsp.valid missing after an accepted read request");

  // first cycle out of reset
  idle_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> !busy && !done && !rd_rsp.valid
  ) else $error("busy, done or rd_rsp.valid high right after reset");

endmodule

bind matmul_top matmul_checker checker_i (
  .clk   (clk),
  .reset (reset),
  .start (start),
  .rd_req(rd_req),
  .rd_rsp(rd_rsp),
  .busy  (busy),
  .done  (done)
);

// File: bench/matmul_tb.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module matmul_tb
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
();

  localparam int CLK_HALF     = 5;
  localparam int RESET_CYCLES = 10;
  // identity, wraparound, five chained, two for the busy test, one for readback
  localparam int RUNS         = 1 + 1 + 5 + 2 + 1;
  localparam int WATCHDOG     = RUNS * (`MM_DONE_LATENCY + 40) + RESET_CYCLES;
  localparam int DONE_LIMIT   = `MM_DONE_LATENCY + 10;

  // m[i][j] is row i, column j
  typedef elem_t [`MM_N-1:0][`MM_N-1:0] mat_t;

  logic      clk;
  logic      reset;
  load_cmd_t load;
  logic      start;
  read_req_t rd_req;
  read_rsp_t rd_rsp;
  logic      busy;
  logic      done;

  row_t exp_q [$];
  int   errors;
  int   done_count;

  matmul_top matmul_top_i (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .start (start),
    .rd_req(rd_req),
    .rd_rsp(rd_rsp),
    .busy  (busy),
    .done  (done)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // C[i][j] is the sum over k of A[i][k] * B[k][j] mod 256
  function automatic tile_t ref_matmul(input mat_t a, input mat_t b);
    tile_t c;
    int    sum;
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        sum = 0;
        for (int k = 0; k < `MM_N; k++) begin
          sum += (a[i][k] * b[k][j]) % 256;
        end
        c[i][j] = elem_t'(sum % 256);
      end
    end
    return c;
  endfunction

  function automatic mat_t random_matrix();
    mat_t m;
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        m[i][j] = elem_t'($urandom);
      end
    end
    return m;
  endfunction

  // column k of a matrix with row 0 in lane 0
  function automatic row_t column_word(input mat_t m, input int k);
    row_t word;
    for (int r = 0; r < `MM_N; r++) begin
      word[r] = m[r][k];
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual == expected) else begin
      $display("CHECK FAILED %s expected %0h got %0h", name, expected, actual);
      errors++;
    end
  endtask

  //////////////////////////////
  // host side tasks
  //////////////////////////////

  task automatic write_word(input mat_sel_t sel, input addr_t addr, input row_t word);
    @(posedge clk);
    load.en   <= 1'b1;
    load.sel  <= sel;
    load.addr <= addr;
    load.row  <= word;
  endtask

  // A goes in by columns, B by rows
  task automatic load_matrices(input mat_t a, input mat_t b);
    for (int k = 0; k < `MM_N; k++) begin
      write_word(sel_a, addr_t'(k), column_word(a, k));
      write_word(sel_b, addr_t'(k), row_t'(b[k]));
    end
    @(posedge clk);
    load.en <= 1'b0;
  endtask

  task automatic start_run();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done && cycles < DONE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (done) else begin
      $display("no done pulse within %0d cycles of start", DONE_LIMIT);
      errors++;
    end
    if (done) begin
      // busy holds through the done cycle
      check_value("busy", 64'(1), 64'(busy));
    end
  endtask

  // request all C rows, then wait for the comparing process to catch up
  task automatic read_result(input tile_t expected);
    int cycles;
    for (int r = 0; r < `MM_N; r++) begin
      @(posedge clk);
      rd_req.en   <= 1'b1;
      rd_req.addr <= addr_t'(r);
      exp_q.push_back(expected[r]);
    end
    @(posedge clk);
    rd_req.en <= 1'b0;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 4 * `MM_READ_LATENCY) begin
      @(negedge clk);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0d read responses never arrived", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic run_and_check(input mat_t a, input mat_t b);
    load_matrices(a, b);
    start_run();
    wait_done();
    read_result(ref_matmul(a, b));
  endtask

  //////////////////////////////
  // comparing process
  //////////////////////////////

  always @(negedge clk) begin
    row_t expected;
    if (!reset && rd_rsp.valid) begin
      assert (exp_q.size() != 0) else begin
        $display("read response arrived with no accepted request");
        errors++;
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        check_value("rd_rsp.row", 64'(expected), 64'(rd_rsp.row));
      end
    end
  end

  always @(negedge clk) begin
    if (!reset && done) begin
      done_count++;
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("simulation timed out after %0d cycles", WATCHDOG);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    mat_t  a;
    mat_t  b;
    tile_t expected;
    int    count_before;

    errors     = 0;
    done_count = 0;
    void'($urandom(24447));
    reset  <= 1'b1;
    load   <= '0;
    start  <= 1'b0;
    rd_req <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // idle outputs and an empty C memory
    @(negedge clk);
    check_value("busy", 64'(0), 64'(busy));
    check_value("done", 64'(0), 64'(done));
    check_value("rd_rsp.valid", 64'(0), 64'(rd_rsp.valid));
    read_result('0);

    // identity times B
    a = '0;
    for (int i = 0; i < `MM_N; i++) begin
      a[i][i] = 8'd1;
    end
    b = random_matrix();
    run_and_check(a, b);

    // full range operands so the sums wrap
    a = random_matrix();
    b = random_matrix();
    a[0][0] = 8'hff;
    b[0][0] = 8'hff;
    run_and_check(a, b);

    repeat (5) begin
      a = random_matrix();
      b = random_matrix();
      run_and_check(a, b);
    end

    // start and load while busy must be dropped
    a = random_matrix();
    b = random_matrix();
    expected = ref_matmul(a, b);
    load_matrices(a, b);
    count_before = done_count;
    start_run();
    repeat (4) @(posedge clk);
    start     <= 1'b1;
    load.en   <= 1'b1;
    load.sel  <= sel_a;
    load.addr <= '0;
    load.row  <= ~column_word(a, 0);
    @(posedge clk);
    start   <= 1'b0;
    load.en <= 1'b0;
    wait_done();
    // rerun on the same memories in the cycle after done
    start_run();
    wait_done();
    read_result(expected);
    check_value("done pulses", 64'(2), 64'(done_count - count_before));

    // readback while busy gets no response
    start_run();
    repeat (6) @(posedge clk);
    rd_req.en   <= 1'b1;
    rd_req.addr <= '0;
    @(posedge clk);
    rd_req.en <= 1'b0;
    wait_done();
    read_result(expected);

    repeat (4) @(negedge clk);
    $display("checks failed: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: include/mm_cfg.svh
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// array size and element width
`define MM_N 4
`define MM_DWIDTH 8

// row memories
`define MM_AWIDTH 7
`define MM_MEM_WORDS 128

// deepest lane delay in the operand skew
`define MM_SKEW_MAX (`MM_N - 1)

// start to capture: N read cycles, one RAM cycle, the skew and the grid hops
// to cell (N-1,N-1), plus the accumulate edge
`define MM_RUN_CYCLES (3 * `MM_N)

// capture, N row writes to C, then done
`define MM_DONE_LATENCY (`MM_RUN_CYCLES + `MM_N + 1)

// request register plus registered RAM read
`define MM_READ_LATENCY 2

`endif

// File: list.f
+incdir+include
logic/mm_data_pkg.sv
logic/mm_ctrl_pkg.sv
logic/row_ram.sv
logic/operand_feeder.sv
logic/systolic_array.sv
logic/result_drain.sv
logic/matmul_top.sv
bench/matmul_checker.sv
bench/matmul_tb.sv

// File: logic/matmul_top.sv
`timescale 1ns/1ps

module matmul_top
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  load_cmd_t load,
  input  logic      start,
  input  read_req_t rd_req,
  output read_rsp_t rd_rsp,
  output logic      busy,
  output logic      done
);

  logic  clear;
  logic  capture;
  row_t  a_lanes;
  row_t  b_lanes;
  tile_t acc;

  operand_feeder feeder_i (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .start  (start),
    .done   (done),
    .busy   (busy),
    .clear  (clear),
    .capture(capture),
    .a_lanes(a_lanes),
    .b_lanes(b_lanes)
  );

  systolic_array array_i (
    .clk    (clk),
    .reset  (reset),
    .clear  (clear),
    .a_lanes(a_lanes),
    .b_lanes(b_lanes),
    .acc    (acc)
  );

  result_drain drain_i (
    .clk    (clk),
    .reset  (reset),
    .busy   (busy),
    .capture(capture),
    .acc    (acc),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .done   (done)
  );

endmodule

// File: logic/mm_ctrl_pkg.sv
`include "mm_cfg.svh"

package mm_ctrl_pkg;

  import mm_data_pkg::*;

  //////////////////////////////
  // host side control
  //////////////////////////////

  typedef enum logic {
    sel_a,
    sel_b
  } mat_sel_t;

  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // one row word written into A or B
  typedef struct packed {
    logic     en;
    mat_sel_t sel;
    addr_t    addr;
    row_t     row;
  } load_cmd_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } read_req_t;

  typedef struct packed {
    logic valid;
    row_t row;
  } read_rsp_t;

endpackage

// File: logic/mm_data_pkg.sv
`include "mm_cfg.svh"

package mm_data_pkg;

  //////////////////////////////
  // matrix data
  //////////////////////////////

  // one unsigned element, arithmetic wraps at this width
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // one memory word or one lane vector, lane 0 in the low bits
  typedef elem_t [`MM_N-1:0] row_t;

  // all accumulators, row i holds C[i][*]
  typedef row_t [`MM_N-1:0] tile_t;

endpackage

// File: logic/operand_feeder.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module operand_feeder
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  load_cmd_t load,
  input  logic      start,
  input  logic      done,
  output logic      busy,
  output logic      clear,
  output logic      capture,
  output row_t      a_lanes,
  output row_t      b_lanes
);

  localparam int CNT_W = $clog2(`MM_DONE_LATENCY + 1);

  logic [CNT_W-1:0] run_cnt;
  logic             rd_phase;
  logic             feed_valid;
  logic             a_we;
  logic             b_we;
  addr_t            mem_addr;
  row_t             a_rdata;
  row_t             b_rdata;
  row_t             a_feed;
  row_t             b_feed;

  //////////////////////////////
  // run sequencer
  //////////////////////////////

  // accepted start
  assign clear = start && !busy;

  // run_cnt is 1 in the first busy cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      run_cnt    <= '0;
      feed_valid <= 1'b0;
    end else begin
      if (clear) begin
        busy    <= 1'b1;
        run_cnt <= CNT_W'(1);
      end else if (done) begin
        busy    <= 1'b0;
        run_cnt <= '0;
      end else if (busy) begin
        run_cnt <= run_cnt + CNT_W'(1);
      end
      // RAM data shows up one cycle after its address
      feed_valid <= rd_phase;
    end
  end

  assign rd_phase = busy && (run_cnt <= CNT_W'(`MM_N));
  assign capture  = busy && (run_cnt == CNT_W'(`MM_RUN_CYCLES));

  //////////////////////////////
  // A and B memories
  //////////////////////////////

  // host owns the port only while idle
  assign mem_addr = busy ? addr_t'(run_cnt - CNT_W'(1)) : load.addr;
  assign a_we     = load.en && !busy && (load.sel == sel_a);
  assign b_we     = load.en && !busy && (load.sel == sel_b);

  row_ram #(
    .word_t(row_t),
    .DEPTH (`MM_MEM_WORDS)
  ) a_ram (
    .clk  (clk),
    .reset(reset),
    .addr (mem_addr),
    .we   (a_we),
    .wdata(load.row),
    .rdata(a_rdata)
  );

  row_ram #(
    .word_t(row_t),
    .DEPTH (`MM_MEM_WORDS)
  ) b_ram (
    .clk  (clk),
    .reset(reset),
    .addr (mem_addr),
    .we   (b_we),
    .wdata(load.row),
    .rdata(b_rdata)
  );

  // zeros outside the operand window keep the sums clean
  assign a_feed = feed_valid ? a_rdata : '0;
  assign b_feed = feed_valid ? b_rdata : '0;

  //////////////////////////////
  // lane skew
  //////////////////////////////

  assign a_lanes[0] = a_feed[0];
  assign b_lanes[0] = b_feed[0];

  // lane l is delayed l cycles
  for (genvar l = 1; l <= `MM_SKEW_MAX; l++) begin : g_skew
    elem_t a_dly [l];
    elem_t b_dly [l];

    always_ff @(posedge clk) begin
      if (reset || clear) begin
        a_dly <= '{default: '0};
        b_dly <= '{default: '0};
      end else begin
        a_dly[0] <= a_feed[l];
        b_dly[0] <= b_feed[l];
        for (int d = 1; d < l; d++) begin
          a_dly[d] <= a_dly[d-1];
          b_dly[d] <= b_dly[d-1];
        end
      end
    end

    assign a_lanes[l] = a_dly[l-1];
    assign b_lanes[l] = b_dly[l-1];
  end

endmodule

// File: logic/result_drain.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module result_drain
  import mm_data_pkg::*;
  import mm_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      busy,
  input  logic      capture,
  input  tile_t     acc,
  input  read_req_t rd_req,
  output read_rsp_t rd_rsp,
  output logic      done
);

  localparam int ROW_W = $clog2(`MM_N);

  tile_t                        tile_q;
  logic                         draining;
  logic [ROW_W-1:0]             row_idx;
  logic                         last_row;
  logic                         rd_accept;
  addr_t                        rd_addr_q;
  logic [`MM_READ_LATENCY-1:0]  rd_vld;
  addr_t                        c_addr;
  row_t                         c_rdata;

  //////////////////////////////
  // tile capture and row writes
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (capture) begin
      tile_q <= acc;
    end
  end

  assign last_row = (row_idx == ROW_W'(`MM_N - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      draining <= 1'b0;
      row_idx  <= '0;
      done     <= 1'b0;
    end else begin
      if (capture) begin
        draining <= 1'b1;
        row_idx  <= '0;
      end else if (draining) begin
        row_idx <= row_idx + ROW_W'(1);
        if (last_row) begin
          draining <= 1'b0;
        end
      end
      // one cycle after the last row write
      done <= draining && last_row;
    end
  end

  //////////////////////////////
  // C memory and readback
  //////////////////////////////

  assign rd_accept = rd_req.en && !busy;

  always_ff @(posedge clk) begin
    rd_addr_q <= rd_req.addr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= {rd_vld[`MM_READ_LATENCY-2:0], rd_accept};
    end
  end

  // the drain owns the port while it writes
  assign c_addr = draining ? addr_t'(row_idx) : rd_addr_q;

  row_ram #(
    .word_t(row_t),
    .DEPTH (`MM_MEM_WORDS)
  ) c_ram (
    .clk  (clk),
    .reset(reset),
    .addr (c_addr),
    .we   (draining),
    .wdata(tile_q[row_idx]),
    .rdata(c_rdata)
  );

  assign rd_rsp.valid = rd_vld[`MM_READ_LATENCY-1];
  assign rd_rsp.row   = c_rdata;

endmodule

// File: logic/row_ram.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module row_ram
  import mm_ctrl_pkg::*;
#(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = `MM_MEM_WORDS
) (
  input  logic  clk,
  input  logic  reset,
  input  addr_t addr,
  input  logic  we,
  input  word_t wdata,
  output word_t rdata
);

  // power-up contents are zero
  word_t mem [DEPTH] = '{default: '0};

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read, old data on a write cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: logic/systolic_array.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module systolic_array
  import mm_data_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  row_t  a_lanes,
  input  row_t  b_lanes,
  output tile_t acc
);

  // a moves right, b moves down, one register per hop
  elem_t a_q   [`MM_N][`MM_N-1];
  elem_t b_q   [`MM_N-1][`MM_N];
  elem_t acc_q [`MM_N][`MM_N];

  //////////////////////////////
  // multiply-accumulate grid
  //////////////////////////////

  for (genvar i = 0; i < `MM_N; i++) begin : g_row
    for (genvar j = 0; j < `MM_N; j++) begin : g_col
      elem_t a_in;
      elem_t b_in;
      elem_t prod;

      // left column takes lane i of A
      if (j == 0) begin : g_a_edge
        assign a_in = a_lanes[i];
      end else begin : g_a_link
        assign a_in = a_q[i][j-1];
      end

      // top row takes lane j of B
      if (i == 0) begin : g_b_edge
        assign b_in = b_lanes[j];
      end else begin : g_b_link
        assign b_in = b_q[i-1][j];
      end

      // product kept to the element width, wraps mod 256
      assign prod = a_in * b_in;

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          acc_q[i][j] <= '0;
        end else begin
          acc_q[i][j] <= acc_q[i][j] + prod;
        end
      end

      // no pass register past the last column
      if (j < `MM_N - 1) begin : g_pass_a
        always_ff @(posedge clk) begin
          if (reset || clear) begin
            a_q[i][j] <= '0;
          end else begin
            a_q[i][j] <= a_in;
          end
        end
      end

      // or below the last row
      if (i < `MM_N - 1) begin : g_pass_b
        always_ff @(posedge clk) begin
          if (reset || clear) begin
            b_q[i][j] <= '0;
          end else begin
            b_q[i][j] <= b_in;
          end
        end
      end
    end
  end

  // pack the accumulators into the tile
  always_comb begin
    for (int r = 0; r < `MM_N; r++) begin
      for (int c = 0; c < `MM_N; c++) begin
        acc[r][c] = acc_q[r][c];
      end
    end
  end

endmodule
